/* verilog.f */
isolde_pkg.sv
isolde_regfile.sv
isolde_word_buffer.sv
isolde_decoder.sv
isolde_operand_stage.sv
isolde_frontend.sv
isolde_tb_clk.sv
isolde_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator and run the front-end testbench; the log is sim.log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module isolde_tb -f verilog.f \
  && ./obj_dir/Visolde_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

/* isolde_tb.sv */
/*
  Testbench of the instruction front end. Loads the scalar registers, sends
  LFSR-driven instructions with idle gaps and checks every issue, illegal pulse
  and busy_o against a model of both register files.
*/
`timescale 1ns/1ns

module isolde_tb;
  import isolde_pkg::*;

  localparam int NumInstr  = 200;
  localparam int MaxCycles = 3000;  // 42 setup + 200 instr at ~6.5 cycles, doubled, slack

  typedef struct packed {
    logic [31:0]                 due;  // cycle of the expected issue
    logic                        illegal;
    isolde_kind_e                kind;
    logic [2:0]                  func3;
    xaddr_t                      rd;
    xaddr_t                      rd2;
    logic [2:0][WordWidth-1:0]   xop;
    quad_t [1:0]                 qop;
    logic [2:0][WordWidth-1:0]   imm;
    logic [2:0]                  imm_valid;
  } issue_t;

  logic         clk;
  logic         rst_n;
  logic         word_valid;
  word_t        word;
  logic         xrf_we;
  xaddr_t       xrf_waddr;
  word_t        xrf_wdata;
  logic         busy;
  logic         exec_valid;
  logic         illegal;
  isolde_kind_e exec_kind;
  logic [2:0]   exec_func3;
  xaddr_t       exec_rd;
  xaddr_t       exec_rd2;
  word_t        exec_xop [NumXRead];
  quad_t        exec_qop [NumQRead];
  word_t        exec_imm [NumImm];
  logic [2:0]   exec_imm_valid;

  word_t       xrf_model [32];
  quad_t       qrf_model [32];  // all zero after reset
  issue_t      expect_q [$];
  word_t       cur_w [MaxWords];
  logic [31:0] lfsr_q = 32'h4a3;
  logic        partial;         // part of a multi-word instruction sent
  int          cycle;
  int          value_errs;
  int          proto_errs;
  int          issues_seen;
  int          legal_sent;

  isolde_tb_clk #(.PeriodNs(40), .ResetCycles(10)) i_clk (.clk_o(clk), .rst_no(rst_n));

  isolde_frontend uut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .word_valid_i    (word_valid),
    .word_i          (word),
    .xrf_we_i        (xrf_we),
    .xrf_waddr_i     (xrf_waddr),
    .xrf_wdata_i     (xrf_wdata),
    .busy_o          (busy),
    .exec_valid_o    (exec_valid),
    .illegal_o       (illegal),
    .exec_kind_o     (exec_kind),
    .exec_func3_o    (exec_func3),
    .exec_rd_o       (exec_rd),
    .exec_rd2_o      (exec_rd2),
    .exec_xop_o      (exec_xop),
    .exec_qop_o      (exec_qop),
    .exec_imm_o      (exec_imm),
    .exec_imm_valid_o(exec_imm_valid)
  );

  // fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output word_t val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = {val[WordWidth-2:0], lfsr_q[0]};
    end
  endtask

  function automatic isolde_kind_e classify_word(input word_t w);
    if (w[6:0] == 7'h2b) return KIND_R_TYPE;
    if (w[6:0] != 7'h0b) return KIND_ILLEGAL;
    case (w[14:12])
      3'd0:    return KIND_VLE32_4;
      3'd1:    return KIND_GEMM;
      3'd2:    return KIND_REDMULE;
      default: return KIND_ILLEGAL;
    endcase
  endfunction

  function automatic int words_for_kind(input isolde_kind_e k);
    case (k)
      KIND_VLE32_4: return 5;
      KIND_GEMM:    return 2;
      KIND_REDMULE: return 4;
      default:      return 1;
    endcase
  endfunction

  task automatic fill_random();
    for (int i = 0; i < MaxWords; i++) begin
      take_bits(32, cur_w[i]);
    end
  endtask

  // opcode and func3 of a legal kind into word 0
  task automatic encode_kind(input isolde_kind_e k);
    case (k)
      KIND_R_TYPE:  cur_w[0][6:0] = 7'h2b;
      KIND_VLE32_4: {cur_w[0][14:12], cur_w[0][6:0]} = {3'd0, 7'h0b};
      KIND_GEMM:    {cur_w[0][14:12], cur_w[0][6:0]} = {3'd1, 7'h0b};
      default:      {cur_w[0][14:12], cur_w[0][6:0]} = {3'd2, 7'h0b};
    endcase
  endtask

  task automatic make_random_instr(output isolde_kind_e k);
    word_t r;
    fill_random();
    take_bits(4, r);
    case (r % 5)
      0: encode_kind(KIND_R_TYPE);
      1: encode_kind(KIND_VLE32_4);
      2: encode_kind(KIND_GEMM);
      3: encode_kind(KIND_REDMULE);
      default: begin
        take_bits(3, r);
        if (r[2]) begin
          {cur_w[0][14:12], cur_w[0][6:0]} = {3'd3 + {1'b0, r[1:0]}, 7'h0b};  // bad func3
        end else if (cur_w[0][6:0] == 7'h0b || cur_w[0][6:0] == 7'h2b) begin
          cur_w[0][4] = ~cur_w[0][4];  // any other opcode
        end
      end
    endcase
    k = classify_word(cur_w[0]);
  endtask

  // expected issue from the field rules, taken after the last word
  task automatic push_expected(input isolde_kind_e k);
    issue_t e;
    word_t  w0;
    word_t  w1;
    w0 = cur_w[0];
    w1 = cur_w[1];
    e = '0;
    e.due = cycle + 2;
    e.illegal = (k == KIND_ILLEGAL);
    e.kind = k;
    e.func3 = w0[14:12];
    if (k == KIND_VLE32_4) begin
      qrf_model[w0[11:7]] = {cur_w[1], cur_w[2], cur_w[3], cur_w[4]};
      return;
    end
    if (k == KIND_R_TYPE || k == KIND_REDMULE) begin
      e.xop = {xrf_model[w0[11:7]], xrf_model[w0[24:20]], xrf_model[w0[19:15]]};
    end
    if (k == KIND_GEMM) begin
      e.xop = {xrf_model[w1[4:0]], xrf_model[w0[24:20]], xrf_model[w0[19:15]]};
      e.rd  = w0[11:7];
      e.rd2 = w1[11:7];
      e.qop = {qrf_model[w1[24:20]], qrf_model[w1[19:15]]};
    end
    if (k == KIND_REDMULE) begin
      e.imm = {cur_w[3], cur_w[2], cur_w[1]};
      e.imm_valid = 3'b111;
    end
    if (!e.illegal) legal_sent++;
    expect_q.push_back(e);
  endtask

  // called 5 ns after a rising edge, returns 5 ns after the sampling edge
  task automatic drive_word(input word_t w, input logic gaps);
    word_t g;
    if (gaps) begin
      take_bits(2, g);
      repeat (g[1:0]) begin
        @(posedge clk);
        #5;
      end
    end
    word_valid = 1'b1;
    word = w;
    @(posedge clk);
    #5;
    word_valid = 1'b0;
  endtask

  task automatic send_instr(input isolde_kind_e k, input logic gaps);
    int len;
    len = words_for_kind(k);
    for (int i = 0; i < len; i++) begin
      drive_word(cur_w[i], gaps);
      partial = (i < len - 1);
    end
    push_expected(k);
  endtask

  task automatic load_scalars();
    word_t v;
    for (int a = 0; a < 32; a++) begin
      take_bits(32, v);
      xrf_we = 1'b1;
      xrf_waddr = xaddr_t'(a);
      xrf_wdata = v;
      xrf_model[a] = v;
      @(posedge clk);
      #5;
    end
    xrf_we = 1'b0;
  endtask

  // load straight into a gemm that reads the loaded quad
  task automatic send_load_gemm_pair();
    xaddr_t dst;
    fill_random();
    encode_kind(KIND_VLE32_4);
    dst = cur_w[0][11:7];
    send_instr(KIND_VLE32_4, 1'b0);
    fill_random();
    encode_kind(KIND_GEMM);
    cur_w[1][19:15] = dst;
    send_instr(KIND_GEMM, 1'b0);
  endtask

  task automatic flag_mismatch(input string what);
    value_errs++;
    $display("CHECK FAILED at %0t ns: %s", $time, what);
  endtask

  task automatic compare_issue(input issue_t e);
    assert (e.due == cycle) else flag_mismatch($sformatf("issue in cycle %0d, due %0d",
                                                         cycle, e.due));
    assert (illegal == e.illegal && exec_valid == !e.illegal)
      else flag_mismatch($sformatf("exec_valid %0b illegal %0b", exec_valid, illegal));
    if (e.illegal) return;
    assert (exec_kind == e.kind && exec_func3 == e.func3 && exec_rd == e.rd &&
            exec_rd2 == e.rd2 && exec_imm_valid == e.imm_valid)
      else flag_mismatch($sformatf("kind %0d func3 %0d rd %0d rd2 %0d, expected %0d %0d %0d %0d",
                                   exec_kind, exec_func3, exec_rd, exec_rd2,
                                   e.kind, e.func3, e.rd, e.rd2));
    for (int i = 0; i < NumXRead; i++) begin
      assert (exec_xop[i] == e.xop[i])
        else flag_mismatch($sformatf("xop%0d %h, expected %h", i, exec_xop[i], e.xop[i]));
      assert (exec_imm[i] == e.imm[i])
        else flag_mismatch($sformatf("imm%0d %h, expected %h", i, exec_imm[i], e.imm[i]));
    end
    if (e.kind == KIND_GEMM) begin
      for (int i = 0; i < NumQRead; i++) begin
        assert (exec_qop[i] == e.qop[i])
          else flag_mismatch($sformatf("qop%0d %h, expected %h", i, exec_qop[i], e.qop[i]));
      end
    end
  endtask

  // sampled at the falling edge, away from the driven inputs
  always @(negedge clk) begin
    if (!rst_n) begin
      assert (!exec_valid && !illegal && !busy) else flag_mismatch("outputs high in reset");
    end else begin
      assert (busy == partial) else flag_mismatch($sformatf("busy_o %0b", busy));
      if (expect_q.size() > 0 && expect_q[0].due < cycle) begin
        proto_errs++;
        $display("no issue seen for the instruction due in cycle %0d", expect_q[0].due);
        void'(expect_q.pop_front());
      end
      if (exec_valid) issues_seen++;
      if (exec_valid || illegal) begin
        if (expect_q.size() == 0) begin
          proto_errs++;
          $display("issue in cycle %0d with no instruction pending", cycle);
        end else begin
          compare_issue(expect_q.pop_front());
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
  end

  initial begin
    wait (cycle >= MaxCycles);
    $display("timeout: run did not finish within %0d cycles", MaxCycles);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    isolde_kind_e k;
    word_valid = 1'b0;
    word = '0;
    xrf_we = 1'b0;
    xrf_waddr = '0;
    xrf_wdata = '0;
    partial = 1'b0;
    for (int a = 0; a < 32; a++) begin
      qrf_model[a] = '0;
    end
    wait (rst_n);
    @(posedge clk);
    #5;
    load_scalars();
    send_load_gemm_pair();
    for (int n = 0; n < NumInstr; n++) begin
      make_random_instr(k);
      send_instr(k, 1'b1);
    end
    repeat (6) @(posedge clk);
    @(negedge clk);
    #1;
    assert (expect_q.size() == 0) else flag_mismatch("issues still pending at the end");
    assert (issues_seen == legal_sent)
      else flag_mismatch($sformatf("%0d issues for %0d legal instructions",
                                   issues_seen, legal_sent));
    $display("errors: %0d value, %0d protocol; %0d issues, %0d legal instructions sent",
             value_errs, proto_errs, issues_seen, legal_sent);
    if (value_errs + proto_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* isolde_tb_clk.sv */
/*
  Clock and reset source for the front-end testbench. Reset is held low for
  ResetCycles rising edges and released shortly after the last one.
*/
`timescale 1ns/1ns

module isolde_tb_clk #(
  parameter int PeriodNs    = 40,
  parameter int ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #5;
    rst_no = 1'b1;  // released between edges
  end

endmodule

/* isolde_frontend.sv */
/*
  Top level of the custom-instruction front end. Chains word buffer, decoder
  and operand stage; an issue appears two cycles after its last word.
*/
`timescale 1ns/1ns

module isolde_frontend (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     word_valid_i,
  input  isolde_pkg::word_t        word_i,
  input  logic                     xrf_we_i,
  input  isolde_pkg::xaddr_t       xrf_waddr_i,
  input  isolde_pkg::word_t        xrf_wdata_i,
  output logic                     busy_o,
  output logic                     exec_valid_o,
  output logic                     illegal_o,
  output isolde_pkg::isolde_kind_e exec_kind_o,
  output logic [2:0]               exec_func3_o,
  output isolde_pkg::xaddr_t       exec_rd_o,
  output isolde_pkg::xaddr_t       exec_rd2_o,
  output isolde_pkg::word_t        exec_xop_o [isolde_pkg::NumXRead],
  output isolde_pkg::quad_t        exec_qop_o [isolde_pkg::NumQRead],
  output isolde_pkg::word_t        exec_imm_o [isolde_pkg::NumImm],
  output logic [2:0]               exec_imm_valid_o
);
  import isolde_pkg::*;

  logic         batch_valid;
  word_t        batch_words [MaxWords];
  logic         dec_valid;
  isolde_kind_e dec_kind;
  logic [2:0]   dec_func3;
  xaddr_t       dec_rd;
  xaddr_t       dec_rd2;
  xaddr_t       dec_xaddr [NumXRead];
  xaddr_t       dec_qaddr [NumQRead];
  word_t        dec_imm [NumImm];
  logic [2:0]   dec_imm_valid;
  logic         dec_qwe;
  xaddr_t       dec_qwaddr;
  quad_t        dec_qwdata;

  isolde_word_buffer i_word_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .word_valid_i (word_valid_i),
    .word_i       (word_i),
    .batch_valid_o(batch_valid),
    .batch_words_o(batch_words),
    .busy_o       (busy_o)
  );

  isolde_decoder i_decoder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .batch_valid_i  (batch_valid),
    .batch_words_i  (batch_words),
    .dec_valid_o    (dec_valid),
    .dec_kind_o     (dec_kind),
    .dec_func3_o    (dec_func3),
    .dec_rd_o       (dec_rd),
    .dec_rd2_o      (dec_rd2),
    .dec_xaddr_o    (dec_xaddr),
    .dec_qaddr_o    (dec_qaddr),
    .dec_imm_o      (dec_imm),
    .dec_imm_valid_o(dec_imm_valid),
    .dec_qwe_o      (dec_qwe),
    .dec_qwaddr_o   (dec_qwaddr),
    .dec_qwdata_o   (dec_qwdata)
  );

  isolde_operand_stage i_operand_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .dec_valid_i     (dec_valid),
    .dec_kind_i      (dec_kind),
    .dec_func3_i     (dec_func3),
    .dec_rd_i        (dec_rd),
    .dec_rd2_i       (dec_rd2),
    .dec_xaddr_i     (dec_xaddr),
    .dec_qaddr_i     (dec_qaddr),
    .dec_imm_i       (dec_imm),
    .dec_imm_valid_i (dec_imm_valid),
    .dec_qwe_i       (dec_qwe),
    .dec_qwaddr_i    (dec_qwaddr),
    .dec_qwdata_i    (dec_qwdata),
    .xrf_we_i        (xrf_we_i),
    .xrf_waddr_i     (xrf_waddr_i),
    .xrf_wdata_i     (xrf_wdata_i),
    .exec_valid_o    (exec_valid_o),
    .illegal_o       (illegal_o),
    .exec_kind_o     (exec_kind_o),
    .exec_func3_o    (exec_func3_o),
    .exec_rd_o       (exec_rd_o),
    .exec_rd2_o      (exec_rd2_o),
    .exec_xop_o      (exec_xop_o),
    .exec_qop_o      (exec_qop_o),
    .exec_imm_o      (exec_imm_o),
    .exec_imm_valid_o(exec_imm_valid_o)
  );

endmodule

/* isolde_operand_stage.sv */
/*
  Stage 3. Reads the scalar and quad register files with the decoded
  addresses, commits quad loads and presents one issue a cycle after
  dec_valid_i. Scalar registers are written from the external port only.
*/
`timescale 1ns/1ns

module isolde_operand_stage (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     dec_valid_i,
  input  isolde_pkg::isolde_kind_e dec_kind_i,
  input  logic [2:0]               dec_func3_i,
  input  isolde_pkg::xaddr_t       dec_rd_i,
  input  isolde_pkg::xaddr_t       dec_rd2_i,
  input  isolde_pkg::xaddr_t       dec_xaddr_i [isolde_pkg::NumXRead],
  input  isolde_pkg::xaddr_t       dec_qaddr_i [isolde_pkg::NumQRead],
  input  isolde_pkg::word_t        dec_imm_i [isolde_pkg::NumImm],
  input  logic [2:0]               dec_imm_valid_i,
  input  logic                     dec_qwe_i,
  input  isolde_pkg::xaddr_t       dec_qwaddr_i,
  input  isolde_pkg::quad_t        dec_qwdata_i,
  input  logic                     xrf_we_i,
  input  isolde_pkg::xaddr_t       xrf_waddr_i,
  input  isolde_pkg::word_t        xrf_wdata_i,
  output logic                     exec_valid_o,
  output logic                     illegal_o,
  output isolde_pkg::isolde_kind_e exec_kind_o,
  output logic [2:0]               exec_func3_o,
  output isolde_pkg::xaddr_t       exec_rd_o,
  output isolde_pkg::xaddr_t       exec_rd2_o,
  output isolde_pkg::word_t        exec_xop_o [isolde_pkg::NumXRead],
  output isolde_pkg::quad_t        exec_qop_o [isolde_pkg::NumQRead],
  output isolde_pkg::word_t        exec_imm_o [isolde_pkg::NumImm],
  output logic [2:0]               exec_imm_valid_o
);
  import isolde_pkg::*;

  logic issue_kind;  // kinds that go to the execution unit

  assign issue_kind = (dec_kind_i == KIND_R_TYPE) || (dec_kind_i == KIND_GEMM) ||
                      (dec_kind_i == KIND_REDMULE);

  isolde_regfile #(.data_t(word_t), .NumRead(NumXRead)) i_xrf (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .raddr_i(dec_xaddr_i),
    .we_i   (xrf_we_i),
    .waddr_i(xrf_waddr_i),
    .wdata_i(xrf_wdata_i),
    .rdata_o(exec_xop_o)
  );

  // quad load commits at the edge of its would-be exec slot
  isolde_regfile #(.data_t(quad_t), .NumRead(NumQRead)) i_qrf (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .raddr_i(dec_qaddr_i),
    .we_i   (dec_qwe_i),
    .waddr_i(dec_qwaddr_i),
    .wdata_i(dec_qwdata_i),
    .rdata_o(exec_qop_o)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exec_valid_o <= 1'b0;
      illegal_o    <= 1'b0;
    end else begin
      exec_valid_o <= dec_valid_i && issue_kind;
      illegal_o    <= dec_valid_i && (dec_kind_i == KIND_ILLEGAL);
    end
  end

  // fields travel next to the register reads
  always_ff @(posedge clk_i) begin
    exec_kind_o      <= dec_kind_i;
    exec_func3_o     <= dec_func3_i;
    exec_rd_o        <= dec_rd_i;
    exec_rd2_o       <= dec_rd2_i;
    exec_imm_o       <= dec_imm_i;
    exec_imm_valid_o <= dec_imm_valid_i;
  end

endmodule

/* isolde_decoder.sv */
/*
  Stage 2. Decodes a complete batch into kind, register addresses,
  immediates and the quad-load write. Outputs are registered one cycle after
  batch_valid_i; fields that a kind does not use are zero.
*/
`timescale 1ns/1ns

module isolde_decoder (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    batch_valid_i,
  input  isolde_pkg::word_t       batch_words_i [isolde_pkg::MaxWords],
  output logic                    dec_valid_o,
  output isolde_pkg::isolde_kind_e dec_kind_o,
  output logic [2:0]              dec_func3_o,
  output isolde_pkg::xaddr_t      dec_rd_o,
  output isolde_pkg::xaddr_t      dec_rd2_o,
  output isolde_pkg::xaddr_t      dec_xaddr_o [isolde_pkg::NumXRead],
  output isolde_pkg::xaddr_t      dec_qaddr_o [isolde_pkg::NumQRead],
  output isolde_pkg::word_t       dec_imm_o [isolde_pkg::NumImm],
  output logic [2:0]              dec_imm_valid_o,
  output logic                    dec_qwe_o,
  output isolde_pkg::xaddr_t      dec_qwaddr_o,
  output isolde_pkg::quad_t       dec_qwdata_o
);
  import isolde_pkg::*;

  isolde_kind_e kind_d;
  xaddr_t       rd_d;
  xaddr_t       rd2_d;
  xaddr_t       xaddr_d [NumXRead];
  xaddr_t       qaddr_d [NumQRead];
  word_t        imm_d [NumImm];
  logic [2:0]   imm_valid_d;
  xaddr_t       qwaddr_d;
  quad_t        qwdata_d;
  word_t        w0;
  word_t        w1;

  assign w0     = batch_words_i[0];
  assign w1     = batch_words_i[1];
  assign kind_d = isolde_kind(w0);

  always_comb begin
    rd_d        = '0;
    rd2_d       = '0;
    xaddr_d     = '{default: '0};
    qaddr_d     = '{default: '0};
    imm_d       = '{default: '0};
    imm_valid_d = '0;
    qwaddr_d    = '0;
    qwdata_d    = '0;
    case (kind_d)
      KIND_R_TYPE: begin
        xaddr_d[0] = w0[19:15];  // rs1
        xaddr_d[1] = w0[24:20];  // rs2
        xaddr_d[2] = w0[11:7];   // rd read as third operand
      end
      KIND_VLE32_4: begin
        qwaddr_d = w0[11:7];
        qwdata_d = {batch_words_i[1], batch_words_i[2], batch_words_i[3], batch_words_i[4]};
      end
      KIND_GEMM: begin
        xaddr_d[0] = w0[19:15];
        xaddr_d[1] = w0[24:20];
        xaddr_d[2] = w1[4:0];    // rs3 sits in the low bits of word 1
        rd_d       = w0[11:7];
        qaddr_d[0] = w1[19:15];
        qaddr_d[1] = w1[24:20];
        rd2_d      = w1[11:7];
      end
      KIND_REDMULE: begin
        xaddr_d[0] = w0[19:15];
        xaddr_d[1] = w0[24:20];
        xaddr_d[2] = w0[11:7];
        for (int i = 0; i < NumImm; i++) begin
          imm_d[i] = batch_words_i[i+1];
        end
        imm_valid_d = 3'b111;
      end
      default: ;  // illegal carries no fields
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_o <= 1'b0;
      dec_qwe_o   <= 1'b0;
    end else begin
      dec_valid_o <= batch_valid_i;
      dec_qwe_o   <= batch_valid_i && (kind_d == KIND_VLE32_4);
    end
  end

  // decoded fields, held until the next batch
  always_ff @(posedge clk_i) begin
    if (batch_valid_i) begin
      dec_kind_o      <= kind_d;
      dec_func3_o     <= w0[14:12];
      dec_rd_o        <= rd_d;
      dec_rd2_o       <= rd2_d;
      dec_xaddr_o     <= xaddr_d;
      dec_qaddr_o     <= qaddr_d;
      dec_imm_o       <= imm_d;
      dec_imm_valid_o <= imm_valid_d;
      dec_qwaddr_o    <= qwaddr_d;
      dec_qwdata_o    <= qwdata_d;
    end
  end

endmodule

/* isolde_word_buffer.sv */
/*
  Stage 1. Collects incoming instruction words into a batch. The length is
  taken from the first word; when the last word is sampled, batch_valid_o
  pulses for one cycle and the next word may follow immediately.
*/
`timescale 1ns/1ns

module isolde_word_buffer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              word_valid_i,
  input  isolde_pkg::word_t word_i,
  output logic              batch_valid_o,
  output isolde_pkg::word_t batch_words_o [isolde_pkg::MaxWords],
  output logic              busy_o
);
  import isolde_pkg::*;

  logic [LenWidth-1:0] wr_idx_q;   // slot for the next word
  logic [LenWidth-1:0] len_q;      // expected length, held after word 0
  logic [LenWidth-1:0] len_cur;
  logic [LenWidth-1:0] wr_idx_nxt;
  logic                last_word;
  logic                batch_valid_q;
  word_t               words_q [MaxWords];

  // word 0 decides the length, later words use the stored one
  always_comb begin
    if (wr_idx_q == '0) begin
      len_cur = isolde_length(isolde_kind(word_i));
    end else begin
      len_cur = len_q;
    end
  end

  assign wr_idx_nxt = wr_idx_q + 1'b1;
  assign last_word  = word_valid_i && (wr_idx_nxt == len_cur);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_idx_q      <= '0;
      len_q         <= '0;
      batch_valid_q <= 1'b0;
    end else begin
      batch_valid_q <= last_word;
      if (word_valid_i) begin
        len_q <= len_cur;
        if (last_word) begin
          wr_idx_q <= '0;  // ready for back to back words
        end else begin
          wr_idx_q <= wr_idx_nxt;
        end
      end
    end
  end

  // word storage, read by the decoder during the batch_valid cycle
  always_ff @(posedge clk_i) begin
    if (word_valid_i) begin
      words_q[wr_idx_q] <= word_i;
    end
  end

  assign batch_valid_o = batch_valid_q;
  assign batch_words_o = words_q;
  assign busy_o        = (wr_idx_q != '0);  // partial instruction held

endmodule

/* isolde_regfile.sv */
/*
  Register file with a configurable payload type, NumRead synchronous read
  ports and one write port. A read at the same edge as a write to the same
  address returns the new data. Used for both scalar and quad registers.
*/
`timescale 1ns/1ns

module isolde_regfile #(
  parameter type         data_t  = isolde_pkg::word_t,
  parameter int unsigned NumRead = 1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  isolde_pkg::xaddr_t raddr_i [NumRead],
  input  logic               we_i,
  input  isolde_pkg::xaddr_t waddr_i,
  input  data_t              wdata_i,
  output data_t              rdata_o [NumRead]
);
  import isolde_pkg::*;

  localparam int unsigned NumEntries = 2 ** XAddrWidth;

  data_t mem_q [NumEntries];
  data_t rdata_q [NumRead];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumEntries; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // registered reads, write data bypasses the array on a match
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < NumRead; r++) begin
        rdata_q[r] <= '0;
      end
    end else begin
      for (int r = 0; r < NumRead; r++) begin
        rdata_q[r] <= (we_i && (waddr_i == raddr_i[r])) ? wdata_i : mem_q[raddr_i[r]];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* isolde_pkg.sv */
/*
  Shared widths, opcodes and instruction kinds of the custom-instruction front end.
  Imported by the word buffer, decoder, operand stage, top level and testbench.
*/
package isolde_pkg;

  localparam int unsigned WordWidth  = 32;
  localparam int unsigned MaxWords   = 5;   // longest instruction, quad load
  localparam int unsigned XAddrWidth = 5;   // same for scalar and quad files
  localparam int unsigned LenWidth   = $clog2(MaxWords + 1);
  localparam int unsigned NumXRead   = 3;   // scalar operands per issue
  localparam int unsigned NumQRead   = 2;   // quad operands per issue
  localparam int unsigned NumImm     = 3;   // redmule immediates

  typedef logic [WordWidth-1:0] word_t;
  typedef logic [3:0][WordWidth-1:0] quad_t;  // [3] is the most significant word
  typedef logic [XAddrWidth-1:0] xaddr_t;

  localparam logic [6:0] OpcCustom0 = 7'h0b;
  localparam logic [6:0] OpcCustom1 = 7'h2b;

  typedef enum logic [2:0] {
    KIND_R_TYPE  = 3'd0,
    KIND_VLE32_4 = 3'd1,
    KIND_GEMM    = 3'd2,
    KIND_REDMULE = 3'd3,
    KIND_ILLEGAL = 3'd4
  } isolde_kind_e;

  // classify by opcode and func3 of the first word
  function automatic isolde_kind_e isolde_kind(input word_t word);
    isolde_kind_e kind;
    kind = KIND_ILLEGAL;
    if (word[6:0] == OpcCustom1) begin
      kind = KIND_R_TYPE;
    end else if (word[6:0] == OpcCustom0) begin
      case (word[14:12])
        3'd0:    kind = KIND_VLE32_4;
        3'd1:    kind = KIND_GEMM;
        3'd2:    kind = KIND_REDMULE;
        default: kind = KIND_ILLEGAL;
      endcase
    end
    return kind;
  endfunction

  // instruction length in words, illegal words are consumed alone
  function automatic logic [LenWidth-1:0] isolde_length(input isolde_kind_e kind);
    logic [LenWidth-1:0] len;
    case (kind)
      KIND_R_TYPE:  len = LenWidth'(1);
      KIND_VLE32_4: len = LenWidth'(5);
      KIND_GEMM:    len = LenWidth'(2);
      KIND_REDMULE: len = LenWidth'(4);
      default:      len = LenWidth'(1);
    endcase
    return len;
  endfunction

endpackage
